/* Makefile */
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --assert -j 0
TOP      ?= fpu_tb
FILELIST ?= filelist.f
OBJDIR   ?= obj_dir
PASS_MSG := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Pass only when the simulation prints the pass message on a line of its own
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* filelist.f */
verilog/fpu_pkg.sv
verilog/fpu_decoder.sv
verilog/fpu_issue_buffer.sv
verilog/fpu_classify_stage.sv
verilog/fpu_noncomp_stage.sv
verilog/fpu_top.sv
verification/fpu_props.sv
verification/fpu_tb.sv

/* verification/fpu_props.sv */
// Concurrent checks on the issue buffer handshake that bind attaches to every fpu_issue_buffer
`timescale 1ns/1ps

module fpu_issue_buffer_props
    import fpu_pkg::*;
(
    input logic    clk_i,
    input logic    rst_ni,
    input logic    flush_i,
    input logic    valid_i,
    input logic    ready_o,
    input logic    valid_o,
    input logic    ready_i,
    input dec_op_t dec_o
);

    // ------------------------------------------------------------------------
    // Flush and reset behavior
    // ------------------------------------------------------------------------
    // No request accepted during flush
    flush_blocks_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |-> !ready_o)
        else $error("Issue buffer ready during flush");

    // READY state right out of reset
    ready_after_reset: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> ready_o)
        else $error("Issue buffer not ready after reset");

    // The edge after a flush finds READY, so only the live request is offered
    ready_state_after_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> flush_i || (valid_o == valid_i))
        else $error("Issue buffer offered a held request after flush");

    // ------------------------------------------------------------------------
    // Held request stability
    // ------------------------------------------------------------------------
    held_request_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ready_i && !flush_i |=> flush_i || (valid_o && $stable(dec_o)))
        else $error("Held request changed while downstream stalled");

endmodule

bind fpu_issue_buffer fpu_issue_buffer_props i_props (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .dec_o   (dec_o)
);

/* verification/fpu_tb.sv */
// Self-checking testbench that drives fpu_top with LFSR stimulus against a queued reference model
`timescale 1ns/1ps

module fpu_tb;
    import fpu_pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 5;
    localparam int DIRECTED_TXNS = 16;   // Full throughput for the latency check
    localparam int RANDOM_TXNS   = 300;  // Random writeback stalls and flushes
    localparam int STALL_TXNS    = 200;  // Writeback mostly stalled
    localparam int TXN_TOTAL     = DIRECTED_TXNS + RANDOM_TXNS + STALL_TXNS;

    typedef struct packed {
        fpu_req_t  req;
        fpu_resp_t resp;
    } exp_entry_t;

    logic      clk_i;
    logic      rst_ni;
    logic      flush_i;
    logic      fpu_valid_i;
    logic      fpu_ready_o;
    fpu_req_t  fpu_req_i;
    logic      fpu_valid_o;
    fpu_resp_t fpu_resp_o;
    logic      wb_ready_i;

    logic [31:0] lfsr_q = 32'h2e08;
    exp_entry_t  exp_q[$];          // Accepted requests in acceptance order
    int          value_errors    = 0;
    int          protocol_errors = 0;
    int          n_accepted      = 0;
    int          n_checked       = 0;
    int          edge_count      = 0;
    int          first_accept_edge = -1;
    int          first_out_edge    = -1;
    int          txn_tag         = 0;
    logic        wait_hold       = 1'b0;  // Output stalled on the last edge
    fpu_resp_t   held_resp;

    fpu_top uut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .fpu_valid_i (fpu_valid_i),
        .fpu_ready_o (fpu_ready_o),
        .fpu_req_i   (fpu_req_i),
        .fpu_valid_o (fpu_valid_o),
        .fpu_resp_o  (fpu_resp_o),
        .wb_ready_i  (wb_ready_i)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // Random source and stimulus shaping
    // ------------------------------------------------------------------------
    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    // Operand biased toward zeros, subnormals, infinities and NaNs
    function automatic logic [31:0] random_operand();
        logic [2:0]  kind;
        logic        sign;
        logic [7:0]  expo;
        logic [22:0] man;
        kind = 3'(take_bits(3));
        sign = 1'(take_bits(1));
        expo = 8'(take_bits(8));
        man  = 23'(take_bits(23));
        case (kind)
            3'd0: expo = 8'h00;                    // Subnormal
            3'd1: begin                            // Signed zero
                expo = 8'h00;
                man  = '0;
            end
            3'd2: expo = 8'hff;                    // NaN with a random quiet bit
            3'd3: begin                            // Infinity
                expo = 8'hff;
                man  = '0;
            end
            default: ;                             // Normal
        endcase
        return {sign, expo, man};
    endfunction

    function automatic fpu_req_t random_request(input int tag);
        fpu_req_t   r;
        logic [2:0] sel;
        r.operation = fp_op_e'(3'(take_bits(3)));  // Includes unused codes 6 and 7
        sel         = 3'(take_bits(3));
        r.rm        = (sel != 3'd0) ? 3'(take_bits(2)) : 3'(take_bits(3));
        r.operand_a = random_operand();
        sel         = 3'(take_bits(3));
        if (sel == 3'd0) begin
            r.operand_b = r.operand_a;                 // Equal operands
        end else if (sel == 3'd1) begin
            r.operand_b = r.operand_a ^ 32'h8000_0000; // Opposite sign
        end else begin
            r.operand_b = random_operand();
        end
        r.trans_id = TRANS_ID_BITS'(tag);
        return r;
    endfunction

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic logic is_nan(input logic [31:0] w);
        return (w[30:23] == 8'hff) && (w[22:0] != '0);
    endfunction

    function automatic logic is_snan(input logic [31:0] w);
        return is_nan(w) && !w[22];
    endfunction

    function automatic logic is_zero(input logic [31:0] w);
        return w[30:0] == '0;
    endfunction

    // Signed ordering key where both zeros map to 0
    function automatic logic signed [32:0] order_key(input logic [31:0] w);
        logic signed [32:0] m;
        m = $signed({2'b00, w[30:0]});
        return w[31] ? -m : m;
    endfunction

    function automatic int class_index(input logic [31:0] w);
        if (w[30:23] == 8'hff) begin
            if (w[22:0] == '0) return w[31] ? 0 : 7;
            return w[22] ? 9 : 8;
        end
        if (w[30:23] == 8'h00) begin
            if (w[22:0] == '0) return w[31] ? 3 : 4;
            return w[31] ? 2 : 5;
        end
        return w[31] ? 1 : 6;
    endfunction

    function automatic fpu_resp_t expected_response(input fpu_req_t r);
        fpu_resp_t          e;
        logic [31:0]        a;
        logic [31:0]        b;
        logic               any_nan;
        logic               any_snan;
        logic               illegal;
        logic signed [32:0] ka;
        logic signed [32:0] kb;
        a        = r.operand_a;
        b        = r.operand_b;
        any_nan  = is_nan(a) || is_nan(b);
        any_snan = is_snan(a) || is_snan(b);
        ka       = order_key(a);
        kb       = order_key(b);
        illegal  = 1'b0;
        e        = '0;
        e.trans_id = r.trans_id;
        case (r.operation)
            FSGNJ: begin
                if (r.rm == 3'd0) e.result = {b[31], a[30:0]};
                else if (r.rm == 3'd1) e.result = {~b[31], a[30:0]};
                else if (r.rm == 3'd2) e.result = {a[31] ^ b[31], a[30:0]};
                else illegal = 1'b1;
            end
            FMIN_MAX: begin
                if (r.rm > 3'd1) begin
                    illegal = 1'b1;
                end else begin
                    if (is_nan(a) && is_nan(b)) e.result = QNAN_CANON;
                    else if (is_nan(a)) e.result = b;
                    else if (is_nan(b)) e.result = a;
                    else if (is_zero(a) && is_zero(b)) e.result = r.rm[0] ? (a & b) : (a | b);
                    else if (ka < kb) e.result = r.rm[0] ? b : a;
                    else e.result = r.rm[0] ? a : b;
                    e.status[STATUS_NV] = any_snan;
                end
            end
            FCMP: begin
                if (r.rm > 3'd2) begin
                    illegal = 1'b1;
                end else if (any_nan) begin
                    e.status[STATUS_NV] = (r.rm == 3'd2) ? any_snan : 1'b1;  // EQ is quiet
                end else begin
                    if (r.rm == 3'd0) e.result = FLEN'(ka <= kb);
                    else if (r.rm == 3'd1) e.result = FLEN'(ka < kb);
                    else e.result = FLEN'(ka == kb);
                end
            end
            FCLASS:           e.result = FLEN'(1) << class_index(a);
            FMV_F2X, FMV_X2F: e.result = a;
            default:          illegal = 1'b1;
        endcase
        if (illegal) begin
            e.result            = '0;
            e.status[STATUS_NV] = 1'b1;
        end
        return e;
    endfunction

    function automatic string test_name(input fpu_req_t r);
        case (r.operation)
            FSGNJ:            return "sign_injection";
            FMIN_MAX:         return "min_max";
            FCMP:             return "compare";
            FCLASS:           return "classify";
            FMV_F2X, FMV_X2F: return "move";
            default:          return "illegal_op";
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Monitor sampling pre-edge values on every rising edge
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin : monitor
        exp_entry_t head;
        exp_entry_t entry;
        if (rst_ni) begin
            // Output must not move while writeback stalls
            if (wait_hold && (!fpu_valid_o || fpu_resp_o !== held_resp)) begin
                protocol_errors++;
                $display("Response changed or vanished while writeback was stalled");
            end
            if (fpu_valid_o && wb_ready_i) begin
                if (first_out_edge < 0) first_out_edge = edge_count;
                if (exp_q.size() == 0) begin
                    protocol_errors++;
                    $display("Unexpected response %h with nothing outstanding", fpu_resp_o);
                end else begin
                    head = exp_q.pop_front();
                    n_checked++;
                    if (fpu_resp_o !== head.resp) begin
                        value_errors++;
                        $display("Error %s: expected %h actual %h",
                                 test_name(head.req), head.resp, fpu_resp_o);
                    end
                end
            end
            wait_hold = fpu_valid_o && !wb_ready_i && !flush_i;
            held_resp = fpu_resp_o;
            if (flush_i) exp_q.delete();  // In-flight work is dropped
            if (fpu_valid_i && fpu_ready_o) begin
                // Two stage registers, one of them must be free after this edge
                if (exp_q.size() > 1) begin
                    protocol_errors++;
                    $display("Request accepted while the pipeline had no room for it");
                end
                entry.req  = fpu_req_i;
                entry.resp = expected_response(fpu_req_i);
                exp_q.push_back(entry);
                n_accepted++;
                if (first_accept_edge < 0) first_accept_edge = edge_count;
            end
            edge_count++;
        end
    end

    // ------------------------------------------------------------------------
    // Drivers on the falling edge
    // ------------------------------------------------------------------------
    // Writeback ready is always high in wb_mode 0, mostly high in 1 and mostly low in 2
    task automatic run_requests(input int count, input int wb_mode, input logic flush_en);
        int   base;
        int   issued;
        int   accepted;
        logic pending;
        logic done;
        base    = n_accepted;
        issued  = 0;
        pending = 1'b0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk_i);
            accepted = n_accepted - base;
            if (pending && accepted == issued) pending = 1'b0;  // Taken on last edge
            if (accepted >= count) begin
                done = 1'b1;
            end else begin
                flush_i = flush_en && !flush_i && (take_bits(5) == 0);  // One-cycle pulses
                if (wb_mode == 0) wb_ready_i = 1'b1;
                else if (wb_mode == 1) wb_ready_i = (take_bits(2) != 0);
                else wb_ready_i = (take_bits(2) == 0);
                if (!pending && issued < count && (wb_mode == 0 || take_bits(2) != 0)) begin
                    fpu_req_i   = random_request(txn_tag);
                    fpu_valid_i = 1'b1;
                    pending     = 1'b1;
                    issued++;
                    txn_tag++;
                end else if (!pending) begin
                    fpu_valid_i = 1'b0;
                end
            end
        end
        fpu_valid_i = 1'b0;
        flush_i     = 1'b0;
    endtask

    // Let every outstanding result leave and then watch for strays
    task automatic drain();
        @(negedge clk_i);
        fpu_valid_i = 1'b0;
        flush_i     = 1'b0;
        wb_ready_i  = 1'b1;
        while (exp_q.size() != 0) @(posedge clk_i);
        repeat (4) @(posedge clk_i);
    endtask

    initial begin : main
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        fpu_valid_i = 1'b0;
        fpu_req_i   = '0;
        wb_ready_i  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        run_requests(DIRECTED_TXNS, 0, 1'b0);
        drain();
        if (first_out_edge - first_accept_edge != 2) begin
            value_errors++;
            $display("Error latency: expected 2 actual %0d",
                     first_out_edge - first_accept_edge);
        end
        run_requests(RANDOM_TXNS, 1, 1'b1);
        drain();
        run_requests(STALL_TXNS, 2, 1'b0);
        drain();

        $display("Checked %0d responses: %0d value errors, %0d protocol errors",
                 n_checked, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        #((TXN_TOTAL * 20 + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not finish within the expected time");
        $display("Something failed");
        $finish;
    end

endmodule

/* verilog/fpu_classify_stage.sv */
// First pipeline stage, registers the decoded operation with the class of both operands
`timescale 1ns/1ps

module fpu_classify_stage
    import fpu_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    flush_i,
    input  logic    valid_i,
    output logic    ready_o,
    input  dec_op_t dec_i,
    output logic    valid_o,
    input  logic    ready_i,
    output cls_op_t cls_o
);

    logic    valid_q;
    cls_op_t cls_d;
    cls_op_t cls_q;

    // Sort one FP32 word into its IEEE class
    function automatic fp_class_t classify(fp32_u v);
        fp_class_t c;
        logic      exp_zero;
        logic      exp_ones;
        logic      man_zero;
        exp_zero    = (v.fields.exponent == 8'h00);
        exp_ones    = (v.fields.exponent == 8'hff);
        man_zero    = (v.fields.mantissa == '0);
        c.sign      = v.fields.sign;
        c.zero      = exp_zero && man_zero;
        c.subnormal = exp_zero && !man_zero;
        c.normal    = !exp_zero && !exp_ones;
        c.inf       = exp_ones && man_zero;
        c.snan      = exp_ones && !man_zero && !v.fields.mantissa[22];  // Quiet bit clear
        c.qnan      = exp_ones && v.fields.mantissa[22];
        return c;
    endfunction

    always_comb begin : p_classify
        cls_d.dec     = dec_i;
        cls_d.class_a = classify(dec_i.operand_a);
        cls_d.class_b = classify(dec_i.operand_b);
    end

    // ------------------------------------------------------------------------
    // Stage register
    // ------------------------------------------------------------------------
    assign ready_o = !valid_q || ready_i;  // Empty or draining

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;      // Drop whatever is in flight
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin : p_data
        if (valid_i && ready_o) begin
            cls_q <= cls_d;
        end
    end

    assign valid_o = valid_q;
    assign cls_o   = cls_q;

endmodule

/* verilog/fpu_decoder.sv */
// Combinational decode of issue operation and rm sub-encoding into a unit operation
`timescale 1ns/1ps

module fpu_decoder
    import fpu_pkg::*;
(
    input  fpu_req_t req_i,
    output dec_op_t  dec_o
);

    always_comb begin : decode
        // Operands and tag pass unchanged
        dec_o.operand_a.raw = req_i.operand_a;
        dec_o.operand_b.raw = req_i.operand_b;
        dec_o.trans_id      = req_i.trans_id;
        dec_o.op            = ILLEGAL;  // Anything not matched below

        unique case (req_i.operation)
            // Sign injection, rm 000..010
            FSGNJ: begin
                unique case (req_i.rm)
                    3'b000:  dec_o.op = SGNJ;
                    3'b001:  dec_o.op = SGNJN;
                    3'b010:  dec_o.op = SGNJX;
                    default: dec_o.op = ILLEGAL;
                endcase
            end
            // Min or max, rm 000..001
            FMIN_MAX: begin
                unique case (req_i.rm)
                    3'b000:  dec_o.op = MIN;
                    3'b001:  dec_o.op = MAX;
                    default: dec_o.op = ILLEGAL;
                endcase
            end
            // Compare, rm 000 le, 001 lt, 010 eq
            FCMP: begin
                unique case (req_i.rm)
                    3'b000:  dec_o.op = LE;
                    3'b001:  dec_o.op = LT;
                    3'b010:  dec_o.op = EQ;
                    default: dec_o.op = ILLEGAL;
                endcase
            end
            FCLASS: dec_o.op = CLASS;  // No sub-encoding, rm ignored

            // Both directions are plain bit moves for FP32 in a 32-bit file
            FMV_F2X,
            FMV_X2F: dec_o.op = MOVE;

            default: dec_o.op = ILLEGAL;  // Unused opcodes 6 and 7
        endcase
    end

endmodule

/* verilog/fpu_issue_buffer.sv */
// Issue-side buffer that absorbs a request the pipeline cannot take, inverting the upstream protocol
`timescale 1ns/1ps

module fpu_issue_buffer
    import fpu_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    flush_i,
    // Upstream, issue side
    input  logic    valid_i,
    output logic    ready_o,
    input  dec_op_t dec_i,
    // Downstream, classify stage
    output logic    valid_o,
    input  logic    ready_i,
    output dec_op_t dec_o
);

    typedef enum logic {
        READY,
        STALL
    } state_e;

    state_e  state_q, state_d;
    dec_op_t hold_q;     // Request parked while stalling
    logic    hold_en;    // Capture into hold_q
    logic    use_hold;   // Offer hold_q instead of live request

    // ------------------------------------------------------------------------
    // READY/STALL control
    // ------------------------------------------------------------------------
    always_comb begin : p_ctrl
        ready_o  = 1'b0;
        valid_o  = 1'b0;
        hold_en  = 1'b0;
        use_hold = 1'b0;
        state_d  = state_q;

        unique case (state_q)
            READY: begin
                ready_o = 1'b1;     // Looks ready to issue
                valid_o = valid_i;  // Pass straight through
                // Pipeline full, park the request and stall issue
                if (valid_i && !ready_i) begin
                    ready_o = 1'b0;
                    hold_en = 1'b1;
                    state_d = STALL;
                end
            end
            STALL: begin
                valid_o  = 1'b1;
                use_hold = 1'b1;
                // Held request taken, release issue in the same cycle
                if (ready_i) begin
                    ready_o = 1'b1;
                    state_d = READY;
                end
            end
            default: state_d = READY;
        endcase

        // Flush wins over everything, nothing moves this cycle
        if (flush_i) begin
            ready_o = 1'b0;
            valid_o = 1'b0;
            hold_en = 1'b0;
            state_d = READY;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    // Payload only, qualified by state
    always_ff @(posedge clk_i) begin : p_hold
        if (hold_en) begin
            hold_q <= dec_i;
        end
    end

    assign dec_o = use_hold ? hold_q : dec_i;

endmodule

/* verilog/fpu_noncomp_stage.sv */
// Second pipeline stage, computes result and status of every non-computational operation
`timescale 1ns/1ps

module fpu_noncomp_stage
    import fpu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    input  logic      valid_i,
    output logic      ready_o,
    input  cls_op_t   cls_i,
    output logic      valid_o,
    input  logic      ready_i,
    output fpu_resp_t resp_o
);

    fp32_u     a, b;
    fp_class_t ca, cb;
    logic      a_nan, b_nan;
    logic      any_nan, any_snan;
    logic      both_zero;
    logic      mag_lt;       // |a| < |b|
    logic      mag_gt;       // |a| > |b|
    logic      a_lt_b_ord;   // Total order, -0 below +0
    logic      a_lt_b;       // IEEE less than, zeros equal
    logic      a_eq_b;
    logic [9:0] class_mask;
    logic      valid_q;
    fpu_resp_t resp_d;
    fpu_resp_t resp_q;

    assign a  = cls_i.dec.operand_a;
    assign b  = cls_i.dec.operand_b;
    assign ca = cls_i.class_a;
    assign cb = cls_i.class_b;

    // ------------------------------------------------------------------------
    // Ordering helpers
    // ------------------------------------------------------------------------
    assign a_nan     = ca.snan || ca.qnan;
    assign b_nan     = cb.snan || cb.qnan;
    assign any_nan   = a_nan || b_nan;
    assign any_snan  = ca.snan || cb.snan;
    assign both_zero = ca.zero && cb.zero;

    // Raw bits 30..0 order like magnitudes for non-NaN values
    assign mag_lt = a.raw[FLEN-2:0] < b.raw[FLEN-2:0];
    assign mag_gt = a.raw[FLEN-2:0] > b.raw[FLEN-2:0];

    always_comb begin : p_order
        if (a.fields.sign != b.fields.sign) begin
            a_lt_b_ord = a.fields.sign;    // Negative side is smaller
        end else if (a.fields.sign) begin
            a_lt_b_ord = mag_gt;           // Both negative, larger magnitude is smaller
        end else begin
            a_lt_b_ord = mag_lt;
        end
    end

    assign a_lt_b = a_lt_b_ord && !both_zero;
    assign a_eq_b = (a.raw == b.raw) || both_zero;

    // One-hot class of operand a
    always_comb begin : p_class
        class_mask                 = '0;
        class_mask[CLASS_NEG_INF]  = ca.inf && ca.sign;
        class_mask[CLASS_NEG_NORM] = ca.normal && ca.sign;
        class_mask[CLASS_NEG_SUBN] = ca.subnormal && ca.sign;
        class_mask[CLASS_NEG_ZERO] = ca.zero && ca.sign;
        class_mask[CLASS_POS_ZERO] = ca.zero && !ca.sign;
        class_mask[CLASS_POS_SUBN] = ca.subnormal && !ca.sign;
        class_mask[CLASS_POS_NORM] = ca.normal && !ca.sign;
        class_mask[CLASS_POS_INF]  = ca.inf && !ca.sign;
        class_mask[CLASS_SNAN]     = ca.snan;
        class_mask[CLASS_QNAN]     = ca.qnan;
    end

    // ------------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------------
    always_comb begin : p_result
        resp_d.result   = '0;
        resp_d.status   = '0;
        resp_d.trans_id = cls_i.dec.trans_id;

        unique case (cls_i.dec.op)
            SGNJ:  resp_d.result = {b.fields.sign, a.raw[FLEN-2:0]};
            SGNJN: resp_d.result = {!b.fields.sign, a.raw[FLEN-2:0]};
            SGNJX: resp_d.result = {a.fields.sign ^ b.fields.sign, a.raw[FLEN-2:0]};
            MIN, MAX: begin
                if (a_nan && b_nan) begin
                    resp_d.result = QNAN_CANON;
                end else if (a_nan) begin
                    resp_d.result = b.raw;  // NaN loses to a number
                end else if (b_nan) begin
                    resp_d.result = a.raw;
                end else if (cls_i.dec.op == MIN) begin
                    resp_d.result = a_lt_b_ord ? a.raw : b.raw;
                end else begin
                    resp_d.result = a_lt_b_ord ? b.raw : a.raw;
                end
                resp_d.status[STATUS_NV] = any_snan;
            end
            // Compares are signaling for LE and LT, quiet for EQ
            LE: begin
                resp_d.result            = FLEN'(!any_nan && (a_lt_b || a_eq_b));
                resp_d.status[STATUS_NV] = any_nan;
            end
            LT: begin
                resp_d.result            = FLEN'(!any_nan && a_lt_b);
                resp_d.status[STATUS_NV] = any_nan;
            end
            EQ: begin
                resp_d.result            = FLEN'(!any_nan && a_eq_b);
                resp_d.status[STATUS_NV] = any_snan;
            end
            CLASS: resp_d.result = FLEN'(class_mask);
            MOVE:  resp_d.result = a.raw;                   // Bit-exact, no NaN handling
            default: resp_d.status[STATUS_NV] = 1'b1;       // ILLEGAL, zero result
        endcase
    end

    // ------------------------------------------------------------------------
    // Stage register, result held while writeback stalls
    // ------------------------------------------------------------------------
    assign ready_o = !valid_q || ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin : p_data
        if (valid_i && ready_o) begin
            resp_q <= resp_d;
        end
    end

    assign valid_o = valid_q;
    assign resp_o  = resp_q;

endmodule

/* verilog/fpu_pkg.sv */
// Shared widths, operation codes and stage payload types for the FP32 non-computational unit
package fpu_pkg;

    // ------------------------------------------------------------------------
    // Widths and constants
    // ------------------------------------------------------------------------
    localparam int unsigned FLEN          = 32;  // Operand and result width
    localparam int unsigned TRANS_ID_BITS = 3;   // Scoreboard tag width
    localparam int unsigned STATUS_BITS   = 5;   // NV DZ OF UF NX
    localparam int unsigned STATUS_NV     = 4;   // Invalid operation, the only flag raised here

    localparam logic [FLEN-1:0] QNAN_CANON = 32'h7fc0_0000;  // Canonical quiet NaN

    // FCLASS result bit positions, RISC-V order
    localparam int unsigned CLASS_NEG_INF    = 0;
    localparam int unsigned CLASS_NEG_NORM   = 1;
    localparam int unsigned CLASS_NEG_SUBN   = 2;
    localparam int unsigned CLASS_NEG_ZERO   = 3;
    localparam int unsigned CLASS_POS_ZERO   = 4;
    localparam int unsigned CLASS_POS_SUBN   = 5;
    localparam int unsigned CLASS_POS_NORM   = 6;
    localparam int unsigned CLASS_POS_INF    = 7;
    localparam int unsigned CLASS_SNAN       = 8;
    localparam int unsigned CLASS_QNAN       = 9;

    // ------------------------------------------------------------------------
    // Operation codes
    // ------------------------------------------------------------------------
    // Issue side, sub-operation carried in rm
    typedef enum logic [2:0] {
        FSGNJ,
        FMIN_MAX,
        FCMP,
        FCLASS,
        FMV_F2X,
        FMV_X2F
    } fp_op_e;

    // Internal unit operation after decode
    typedef enum logic [3:0] {
        SGNJ,
        SGNJN,
        SGNJX,
        MIN,
        MAX,
        LE,
        LT,
        EQ,
        CLASS,
        MOVE,
        ILLEGAL
    } unit_op_e;

    // ------------------------------------------------------------------------
    // Operand views
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp32_fields_t;

    // Field view for classification, raw view for magnitude ordering
    typedef union packed {
        fp32_fields_t    fields;
        logic [FLEN-1:0] raw;
    } fp32_u;

    typedef struct packed {
        logic sign;
        logic zero;
        logic subnormal;
        logic normal;
        logic inf;
        logic snan;
        logic qnan;
    } fp_class_t;

    // ------------------------------------------------------------------------
    // Stage payloads
    // ------------------------------------------------------------------------
    typedef struct packed {
        fp_op_e                   operation;
        logic [2:0]               rm;         // Sub-operation select
        logic [FLEN-1:0]          operand_a;
        logic [FLEN-1:0]          operand_b;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fpu_req_t;

    typedef struct packed {
        unit_op_e                 op;
        fp32_u                    operand_a;
        fp32_u                    operand_b;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } dec_op_t;

    typedef struct packed {
        dec_op_t   dec;
        fp_class_t class_a;
        fp_class_t class_b;
    } cls_op_t;

    typedef struct packed {
        logic [FLEN-1:0]          result;
        logic [STATUS_BITS-1:0]   status;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fpu_resp_t;

endpackage

/* verilog/fpu_top.sv */
// Top level of the FP32 non-computational unit, chains decoder, issue buffer and two stages
`timescale 1ns/1ps

module fpu_top
    import fpu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    // Issue port
    input  logic      fpu_valid_i,
    output logic      fpu_ready_o,
    input  fpu_req_t  fpu_req_i,
    // Writeback port
    output logic      fpu_valid_o,
    output fpu_resp_t fpu_resp_o,
    input  logic      wb_ready_i
);

    dec_op_t dec;        // Decoder to buffer
    dec_op_t buf_dec;    // Buffer to classify
    logic    buf_valid;
    logic    cls_ready;
    cls_op_t cls;        // Classify to noncomp
    logic    cls_valid;
    logic    nc_ready;

    fpu_decoder i_decoder (
        .req_i (fpu_req_i),
        .dec_o (dec)
    );

    fpu_issue_buffer i_issue_buffer (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .valid_i (fpu_valid_i),
        .ready_o (fpu_ready_o),
        .dec_i   (dec),
        .valid_o (buf_valid),
        .ready_i (cls_ready),
        .dec_o   (buf_dec)
    );

    fpu_classify_stage i_classify (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .valid_i (buf_valid),
        .ready_o (cls_ready),
        .dec_i   (buf_dec),
        .valid_o (cls_valid),
        .ready_i (nc_ready),
        .cls_o   (cls)
    );

    fpu_noncomp_stage i_noncomp (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .valid_i (cls_valid),
        .ready_o (nc_ready),
        .cls_i   (cls),
        .valid_o (fpu_valid_o),
        .ready_i (wb_ready_i),   // Writeback may stall the pipe
        .resp_o  (fpu_resp_o)
    );

endmodule
